// ==== filelist.f ====
design/motion_pkg.sv
design/frame_sequencer.sv
design/pixel_addr_counter.sv
design/frame_store.sv
design/frame_diff_threshold.sv
design/motion_csr_apb.sv
design/motion_detect_top.sv
verif/motion_detect_properties.sv
verif/motion_detect_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the motion detector testbench with verilator
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module motion_detect_tb \
	-f filelist.f -o motion_sim > build.log 2>&1 \
	&& ./obj_dir/motion_sim > sim.log 2>&1 \
	|| echo "STATUS: FAIL" >> sim.log
cat build.log sim.log
# a build error, a crash or a failed check all leave the fail line in the log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

// ==== verif/motion_detect_tb.sv ====
`timescale 1ns/1ps

module motion_detect_tb;
	import motion_pkg::*;

	localparam int IMG_H         = 8;
	localparam int IMG_V         = 4;
	localparam int FRAME_SKIP    = 1;
	localparam int DEPTH         = IMG_H * IMG_V;
	localparam int BLANK         = 4;       // vsync low cycles between frames
	localparam int APB_TIMEOUT   = 16;
	localparam int DRAIN_TIMEOUT = 200;
	localparam int NUM_ROWS      = 10;

	typedef struct packed {
		logic       diff_mode;
		logic [7:0] thresh;
		logic       motion;    // +100 on cols 0..3
		logic [1:0] extra;     // overflow pixels on last line
	} frame_row_t;

	// row 0 is dropped, rows 1 and 2 fill the banks
	localparam frame_row_t FRAME_TABLE [NUM_ROWS] = '{
		'{1'b1, 8'd20,  1'b0, 2'd0},
		'{1'b1, 8'd20,  1'b0, 2'd1},
		'{1'b1, 8'd20,  1'b1, 2'd0},
		'{1'b1, 8'd20,  1'b1, 2'd2},
		'{1'b1, 8'd20,  1'b0, 2'd0},
		'{1'b0, 8'd20,  1'b1, 2'd1},
		'{1'b1, 8'd99,  1'b1, 2'd0},
		'{1'b1, 8'd200, 1'b1, 2'd2},
		'{1'b1, 8'd3,   1'b1, 2'd0},
		'{1'b0, 8'd20,  1'b0, 2'd1}
	};

	logic                  cmos_pclk = 1'b0;
	logic                  locked;
	cam_pix_t              pix;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [31:0]           pwdata;
	logic [31:0]           prdata;
	logic                  pready;
	logic                  pslverr;
	pix_out_t              out;

	logic [31:0] lcg_state;
	logic [7:0]  last_f [DEPTH];    // previous frame sent, skipped or not
	logic [7:0]  cur_f  [DEPTH];
	logic [7:0]  prev_f [DEPTH];    // last stored frame
	logic [7:0]  old_f  [DEPTH];    // one before that
	logic [7:0]  exp_q  [$];
	logic [7:0]  exp_px;
	logic        vs_d1 = 1'b0;      // input vsync one negedge back
	logic        vs_d2 = 1'b0;      // two negedges back
	int          stored;
	int          cur_row;
	int          total_out;
	int          row_start;
	int          err_cnt;

	always #10 cmos_pclk = ~cmos_pclk;

	motion_detect_top #(.IMG_H(IMG_H), .IMG_V(IMG_V), .FRAME_SKIP(FRAME_SKIP)) motion_detect_top_i (
		.cmos_pclk (cmos_pclk),
		.locked    (locked),
		.pix_i     (pix),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr),
		.out_o     (out)
	);

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [7:0] next_rand_pixel();
		lcg_state = lcg_step(lcg_state);
		return lcg_state[23:16];    // upper bits, less periodic
	endfunction

	function automatic logic [7:0] abs_sub(input logic [7:0] a, input logic [7:0] b);
		return (a > b) ? a - b : b - a;
	endfunction

	task automatic fail_stop(input string reason);
		err_cnt++;
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual)
			fail_stop($sformatf("[ERROR] %s expected %0h actual %0h", name, expected, actual));
	endtask

	task automatic drive_pix(input logic vs, input logic hr, input logic [7:0] px);
		@(posedge cmos_pclk);
		pix <= '{vsync: vs, href: hr, pixel: px};
	endtask

	// setup then access, sampled mid cycle
	task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int cyc;
		@(posedge cmos_pclk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge cmos_pclk);
		penable <= 1'b1;
		cyc = 0;
		@(negedge cmos_pclk);
		while (!pready) begin
			cyc++;
			if (cyc > APB_TIMEOUT)
				fail_stop("APB slave never signalled ready");
			@(negedge cmos_pclk);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge cmos_pclk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic reg_write(input string name, input logic [APB_ADDR_W-1:0] addr,
			input logic [31:0] data, input logic exp_err);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b1, addr, data, rd, err);
		check_value(name, exp_err, err);
	endtask

	task automatic reg_read(input string name, input logic [APB_ADDR_W-1:0] addr,
			input logic [31:0] expected);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b0, addr, 32'd0, rd, err);
		check_value({name, " slverr"}, 32'd0, err);
		check_value(name, expected, rd);
	endtask

	// next frame plus the expected outputs by the three frame rule
	task automatic build_frame(input frame_row_t row);
		logic [7:0] y;
		for (int a = 0; a < DEPTH; a++) begin
			if (row.motion && (a % IMG_H) < 4)
				cur_f[a] = 8'(last_f[a] + 8'd100);
			else
				cur_f[a] = last_f[a];
			if (stored >= 2) begin
				y = abs_sub(prev_f[a], old_f[a]) & abs_sub(cur_f[a], prev_f[a]);
				if (!row.diff_mode)
					exp_q.push_back(cur_f[a]);
				else if (y > row.thresh)
					exp_q.push_back(8'h00);
				else
					exp_q.push_back(8'hFF);
			end
		end
	endtask

	task automatic send_frame(input int extra);
		int len;
		drive_pix(1'b1, 1'b0, 8'h00);    // vsync up, no pixels yet
		drive_pix(1'b1, 1'b0, 8'h00);
		for (int ln = 0; ln < IMG_V; ln++) begin
			len = (ln == IMG_V - 1) ? IMG_H + extra : IMG_H;
			for (int col = 0; col < len; col++) begin
				if (col < IMG_H)
					drive_pix(1'b1, 1'b1, cur_f[ln * IMG_H + col]);
				else
					drive_pix(1'b1, 1'b1, next_rand_pixel());    // past the last address
			end
			drive_pix(1'b1, 1'b0, 8'h00);    // line gap
			drive_pix(1'b1, 1'b0, 8'h00);
		end
		repeat (BLANK) drive_pix(1'b0, 1'b0, 8'h00);
	endtask

	task automatic wait_drain();
		int cyc;
		cyc = 0;
		while (exp_q.size() != 0) begin
			@(negedge cmos_pclk);
			cyc++;
			if (cyc > DRAIN_TIMEOUT)
				fail_stop("timed out waiting for the remaining output pixels");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// output monitor, in order against the queue
	//////////////////////////////////////////////////////////////////////
	always @(negedge cmos_pclk) begin
		// out vsync trails the input by store plus diff stage
		if (locked)
			check_value($sformatf("row %0d out vsync", cur_row), vs_d2, out.vsync);
		vs_d2 = vs_d1;
		vs_d1 = pix.vsync;
		if (locked && out.valid) begin
			if (exp_q.size() == 0)
				fail_stop($sformatf("output pixel in row %0d when none was expected", cur_row));
			exp_px = exp_q.pop_front();
			check_value($sformatf("row %0d pixel %0d", cur_row, total_out - row_start),
				exp_px, out.pixel);
			total_out++;
		end
	end

	initial begin
		frame_row_t  row;
		logic [31:0] status_exp;
		logic [31:0] rd;
		logic        err;
		locked    <= 1'b0;
		pix       <= '0;
		psel      <= 1'b0;
		penable   <= 1'b0;
		pwrite    <= 1'b0;
		paddr     <= '0;
		pwdata    <= '0;
		lcg_state  = 32'd50268;
		stored     = 0;
		cur_row    = 0;
		total_out  = 0;
		row_start  = 0;
		err_cnt    = 0;
		for (int a = 0; a < DEPTH; a++) begin
			last_f[a] = next_rand_pixel();    // base scene
			prev_f[a] = 8'h00;
			old_f[a]  = 8'h00;
		end
		repeat (2) @(posedge cmos_pclk);
		locked <= 1'b1;

		reg_read("ctrl after reset", CSR_CTRL_ADDR, 32'd1);
		reg_read("thresh after reset", CSR_THRESH_ADDR, 32'(DEFAULT_THRESH));
		reg_read("status after reset", CSR_STATUS_ADDR, 32'd0);

		for (int r = 0; r < NUM_ROWS; r++) begin
			row     = FRAME_TABLE[r];
			cur_row = r;
			reg_write("ctrl write slverr", CSR_CTRL_ADDR, 32'(row.diff_mode), 1'b0);
			reg_write("thresh write slverr", CSR_THRESH_ADDR, 32'(row.thresh), 1'b0);
			reg_read("ctrl readback", CSR_CTRL_ADDR, 32'(row.diff_mode));
			reg_read("thresh readback", CSR_THRESH_ADDR, 32'(row.thresh));
			build_frame(row);
			row_start = total_out;
			send_frame(int'(row.extra));
			wait_drain();
			check_value($sformatf("row %0d pixel count", r), (stored >= 2) ? DEPTH : 0,
				total_out - row_start);
			if (r >= FRAME_SKIP) begin
				old_f  = prev_f;
				prev_f = cur_f;
				stored++;
			end
			last_f     = cur_f;
			status_exp = {23'd0, stored >= 2, 8'(stored)};
			reg_read("status after frame", CSR_STATUS_ADDR, status_exp);
		end

		// bad accesses
		reg_write("status write slverr", CSR_STATUS_ADDR, 32'h1FF, 1'b1);
		reg_write("unmapped write slverr", 4'hC, 32'h5A, 1'b1);
		apb_access(1'b0, 4'hC, 32'd0, rd, err);
		check_value("unmapped read slverr", 32'd1, err);
		reg_read("status unchanged", CSR_STATUS_ADDR, status_exp);

		if (err_cnt == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("STATUS: FAIL");
			$fatal(1, "errors were counted");
		end
	end

endmodule

// ==== verif/motion_detect_properties.sv ====
`timescale 1ns/1ps

module motion_detect_properties (
	input logic                 cmos_pclk,
	input logic                 locked,
	input motion_pkg::cam_pix_t pix_i,
	input logic                 psel_i,
	input logic                 penable_i,
	input logic                 pready_i,
	input logic                 pslverr_i,
	input logic                 primed_i,
	input motion_pkg::pix_out_t out_i
);

	// zero wait state slave
	pready_high: assert property (@(posedge cmos_pclk) disable iff (!locked) pready_i)
		else $error("pready went low");

	// banks hold two frames before anything comes out
	valid_needs_primed: assert property (@(posedge cmos_pclk) disable iff (!locked)
		out_i.valid |-> primed_i)
		else $error("output valid while banks not primed");

	// two stage pipe, store then diff
	valid_from_href: assert property (@(posedge cmos_pclk) disable iff (!locked)
		out_i.valid |-> $past(pix_i.href, 2))
		else $error("output valid without href two cycles earlier");

	slverr_in_access: assert property (@(posedge cmos_pclk) disable iff (!locked)
		pslverr_i |-> (psel_i && penable_i))
		else $error("pslverr outside the access phase");

endmodule

bind motion_detect_top motion_detect_properties motion_detect_properties_i (
	.cmos_pclk (cmos_pclk),
	.locked    (locked),
	.pix_i     (pix_i),
	.psel_i    (psel_i),
	.penable_i (penable_i),
	.pready_i  (pready_o),
	.pslverr_i (pslverr_o),
	.primed_i  (primed),
	.out_i     (out_o)
);

// ==== design/motion_detect_top.sv ====
`timescale 1ns/1ps

module motion_detect_top #(
	parameter int IMG_H      = 640,
	parameter int IMG_V      = 480,
	parameter int FRAME_SKIP = 10
) (
	input  logic                              cmos_pclk,
	input  logic                              locked,
	input  motion_pkg::cam_pix_t              pix_i,
	input  logic                              psel_i,
	input  logic                              penable_i,
	input  logic                              pwrite_i,
	input  logic [motion_pkg::APB_ADDR_W-1:0] paddr_i,
	input  logic [31:0]                       pwdata_i,
	output logic [31:0]                       prdata_o,
	output logic                              pready_o,
	output logic                              pslverr_o,
	output motion_pkg::pix_out_t              out_o
);
	import motion_pkg::*;

	localparam int ADDR_W = $clog2(IMG_H * IMG_V);

	logic              store_en;
	bank_idx_t         wr_bank;
	logic              primed;
	pixel_t            frame_count;
	logic [ADDR_W-1:0] pix_addr;
	logic              in_frame;      // pixel inside frame bounds
	pix_triple_t       triple;
	logic              diff_mode;
	pixel_t            threshold;

	//////////////////////////////////////////////////////////////////////
	// frame control
	//////////////////////////////////////////////////////////////////////
	frame_sequencer #(.FRAME_SKIP(FRAME_SKIP)) frame_sequencer_i (
		.cmos_pclk     (cmos_pclk),
		.locked        (locked),
		.vsync_i       (pix_i.vsync),
		.store_en_o    (store_en),
		.wr_bank_o     (wr_bank),
		.primed_o      (primed),
		.frame_count_o (frame_count)
	);

	pixel_addr_counter #(.IMG_H(IMG_H), .IMG_V(IMG_V)) pixel_addr_counter_i (
		.cmos_pclk  (cmos_pclk),
		.locked     (locked),
		.pix_i      (pix_i),
		.addr_o     (pix_addr),
		.in_frame_o (in_frame)
	);

	//////////////////////////////////////////////////////////////////////
	// datapath, store then diff
	//////////////////////////////////////////////////////////////////////
	frame_store #(.IMG_H(IMG_H), .IMG_V(IMG_V)) frame_store_i (
		.cmos_pclk  (cmos_pclk),
		.locked     (locked),
		.pix_i      (pix_i),
		.addr_i     (pix_addr),
		.wr_ok_i    (in_frame),
		.store_en_i (store_en),
		.wr_bank_i  (wr_bank),
		.primed_i   (primed),
		.triple_o   (triple)
	);

	frame_diff_threshold frame_diff_threshold_i (
		.cmos_pclk   (cmos_pclk),
		.locked      (locked),
		.triple_i    (triple),
		.diff_mode_i (diff_mode),
		.threshold_i (threshold),
		.out_o       (out_o)
	);

	// register block, replaces the key inputs
	motion_csr_apb motion_csr_apb_i (
		.cmos_pclk     (cmos_pclk),
		.locked        (locked),
		.psel_i        (psel_i),
		.penable_i     (penable_i),
		.pwrite_i      (pwrite_i),
		.paddr_i       (paddr_i),
		.pwdata_i      (pwdata_i),
		.prdata_o      (prdata_o),
		.pready_o      (pready_o),
		.pslverr_o     (pslverr_o),
		.primed_i      (primed),
		.frame_count_i (frame_count),
		.diff_mode_o   (diff_mode),
		.threshold_o   (threshold)
	);

endmodule

// ==== design/motion_csr_apb.sv ====
`timescale 1ns/1ps

module motion_csr_apb (
	input  logic                              cmos_pclk,
	input  logic                              locked,
	input  logic                              psel_i,
	input  logic                              penable_i,
	input  logic                              pwrite_i,
	input  logic [motion_pkg::APB_ADDR_W-1:0] paddr_i,
	input  logic [31:0]                       pwdata_i,
	output logic [31:0]                       prdata_o,
	output logic                              pready_o,
	output logic                              pslverr_o,
	input  logic                              primed_i,
	input  motion_pkg::pixel_t                frame_count_i,
	output logic                              diff_mode_o,
	output motion_pkg::pixel_t                threshold_o
);
	import motion_pkg::*;

	logic   diff_mode_q;
	pixel_t thresh_q;
	logic   access;      // apb access phase
	logic   addr_hit;    // one of the three registers
	logic   wr_ro;       // write to read-only status
	logic   bad;

	assign access = psel_i & penable_i;

	//////////////////////////////////////////////////////////////////////
	// decode and read mux
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		addr_hit = 1'b1;
		prdata_o = '0;
		case (paddr_i)
			CSR_CTRL_ADDR:   prdata_o[0]   = diff_mode_q;
			CSR_THRESH_ADDR: prdata_o[7:0] = thresh_q;
			CSR_STATUS_ADDR: prdata_o[8:0] = {primed_i, frame_count_i};
			default:         addr_hit      = 1'b0;
		endcase
	end

	assign wr_ro     = pwrite_i & (paddr_i == CSR_STATUS_ADDR);
	assign bad       = ~addr_hit | wr_ro;
	assign pslverr_o = access & bad;    // only in access phase
	assign pready_o  = 1'b1;            // zero wait states

	//////////////////////////////////////////////////////////////////////
	// control registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge cmos_pclk or negedge locked) begin
		if (!locked) begin
			diff_mode_q <= DEFAULT_DIFF_MODE;
			thresh_q    <= DEFAULT_THRESH;
		end else if (access && pwrite_i && !bad) begin
			case (paddr_i)
				CSR_CTRL_ADDR:   diff_mode_q <= pwdata_i[0];
				CSR_THRESH_ADDR: thresh_q    <= pwdata_i[7:0];
				default:         thresh_q    <= thresh_q;    // status is ro
			endcase
		end
	end

	// straight from the regs, datapath sees it next edge
	assign diff_mode_o = diff_mode_q;
	assign threshold_o = thresh_q;

endmodule

// ==== design/frame_diff_threshold.sv ====
`timescale 1ns/1ps

module frame_diff_threshold (
	input  logic                    cmos_pclk,
	input  logic                    locked,
	input  motion_pkg::pix_triple_t triple_i,
	input  logic                    diff_mode_i,
	input  motion_pkg::pixel_t      threshold_i,
	output motion_pkg::pix_out_t    out_o
);
	import motion_pkg::*;

	pixel_t y1;          // |prev - old|
	pixel_t y2;          // |cur - prev|
	pixel_t y;
	pixel_t pix_next;
	pixel_t pix_q;
	logic   valid_q;
	logic   vsync_q;

	function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
		abs_diff = (a >= b) ? a - b : b - a;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// three-frame difference
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		y1 = abs_diff(triple_i.prev, triple_i.old);
		y2 = abs_diff(triple_i.cur, triple_i.prev);
		y  = y1 & y2;    // both frame pairs must have moved
		if (diff_mode_i) begin
			pix_next = (y > threshold_i) ? PIX_BLACK : PIX_WHITE;
		end else begin
			pix_next = triple_i.cur;    // grey passthrough
		end
	end

	always_ff @(posedge cmos_pclk) begin
		pix_q <= pix_next;
	end

	always_ff @(posedge cmos_pclk or negedge locked) begin
		if (!locked) begin
			valid_q <= 1'b0;
			vsync_q <= 1'b0;
		end else begin
			valid_q <= triple_i.valid;
			vsync_q <= triple_i.vsync;
		end
	end

	assign out_o = '{vsync: vsync_q, valid: valid_q, pixel: pix_q};

endmodule

// ==== design/frame_store.sv ====
`timescale 1ns/1ps

module frame_store #(
	parameter  int IMG_H  = 640,
	parameter  int IMG_V  = 480,
	localparam int DEPTH  = IMG_H * IMG_V,
	localparam int ADDR_W = $clog2(DEPTH)
) (
	input  logic                    cmos_pclk,
	input  logic                    locked,
	input  motion_pkg::cam_pix_t    pix_i,
	input  logic [ADDR_W-1:0]       addr_i,
	input  logic                    wr_ok_i,
	input  logic                    store_en_i,
	input  motion_pkg::bank_idx_t   wr_bank_i,
	input  logic                    primed_i,
	output motion_pkg::pix_triple_t triple_o
);
	import motion_pkg::*;

	pixel_t    bank_mem [NUM_BANKS][DEPTH];    // three frame buffers
	bank_idx_t prev_bank;
	bank_idx_t old_bank;
	logic      pix_ok;                         // in-range pixel this cycle
	logic      wr_en;
	pixel_t    cur_q;
	pixel_t    prev_q;
	pixel_t    old_q;
	logic      valid_q;
	logic      vsync_q;

	// wr_bank - 1 and wr_bank - 2, mod 3
	always_comb begin
		case (wr_bank_i)
			2'd0: begin
				prev_bank = 2'd2;
				old_bank  = 2'd1;
			end
			2'd1: begin
				prev_bank = 2'd0;
				old_bank  = 2'd2;
			end
			default: begin
				prev_bank = 2'd1;
				old_bank  = 2'd0;
			end
		endcase
	end

	assign pix_ok = pix_i.href & wr_ok_i;
	assign wr_en  = pix_ok & store_en_i;

	// write current bank, read the two older ones at the same address
	always_ff @(posedge cmos_pclk) begin
		if (wr_en) begin
			bank_mem[wr_bank_i][addr_i] <= pix_i.pixel;
		end
		prev_q <= bank_mem[prev_bank][addr_i];
		old_q  <= bank_mem[old_bank][addr_i];
		cur_q  <= pix_i.pixel;    // aligned with read data
	end

	always_ff @(posedge cmos_pclk or negedge locked) begin
		if (!locked) begin
			valid_q <= 1'b0;
			vsync_q <= 1'b0;
		end else begin
			valid_q <= pix_ok & primed_i;    // nothing out until two frames banked
			vsync_q <= pix_i.vsync;
		end
	end

	assign triple_o = '{vsync: vsync_q, valid: valid_q, cur: cur_q, prev: prev_q, old: old_q};

endmodule

// ==== design/pixel_addr_counter.sv ====
`timescale 1ns/1ps

module pixel_addr_counter #(
	parameter  int IMG_H  = 640,
	parameter  int IMG_V  = 480,
	localparam int DEPTH  = IMG_H * IMG_V,
	localparam int ADDR_W = $clog2(DEPTH)
) (
	input  logic                 cmos_pclk,
	input  logic                 locked,
	input  motion_pkg::cam_pix_t pix_i,
	output logic [ADDR_W-1:0]    addr_o,
	output logic                 in_frame_o
);

	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

	logic [ADDR_W-1:0] addr_q;    // address of the next valid pixel
	logic              full_q;    // last address already taken

	always_ff @(posedge cmos_pclk or negedge locked) begin
		if (!locked) begin
			addr_q <= '0;
			full_q <= 1'b0;
		end else if (!pix_i.vsync) begin
			// blanking, rearm for next frame
			addr_q <= '0;
			full_q <= 1'b0;
		end else if (pix_i.href && !full_q) begin
			if (addr_q == LAST_ADDR) begin
				full_q <= 1'b1;    // hold at last, flag overflow
			end else begin
				addr_q <= addr_q + 1'b1;
			end
		end
	end

	assign addr_o     = addr_q;
	// excess pixels on the last line fall out here
	assign in_frame_o = pix_i.vsync & ~full_q;

endmodule

// ==== design/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer #(
	parameter int FRAME_SKIP = 10
) (
	input  logic                  cmos_pclk,
	input  logic                  locked,
	input  logic                  vsync_i,
	output logic                  store_en_o,
	output motion_pkg::bank_idx_t wr_bank_o,
	output logic                  primed_o,
	output motion_pkg::pixel_t    frame_count_o
);
	import motion_pkg::*;

	localparam int SKIP_W = (FRAME_SKIP > 1) ? $clog2(FRAME_SKIP) : 1;

	typedef enum logic [1:0] {
		SKIP,    // sensor settling, nothing stored
		FILL,    // storing, fewer than two frames banked
		RUN      // all three banks in use
	} seq_state_t;

	seq_state_t        state_q;
	logic [SKIP_W-1:0] skip_cnt_q;    // frames dropped so far
	logic              vs_r0;
	logic              vs_r1;
	logic              frame_end;     // one pulse per vsync fall
	bank_idx_t         bank_q;
	pixel_t            count_q;       // stored frames, wraps

	// 0 -> 1 -> 2 -> 0
	function automatic bank_idx_t next_bank(input bank_idx_t b);
		next_bank = (b == bank_idx_t'(NUM_BANKS - 1)) ? bank_idx_t'(0) : b + 1'b1;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// frame end detect
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge cmos_pclk or negedge locked) begin
		if (!locked) begin
			vs_r0 <= 1'b0;
			vs_r1 <= 1'b0;
		end else begin
			vs_r0 <= vsync_i;
			vs_r1 <= vs_r0;
		end
	end

	assign frame_end = vs_r1 & ~vs_r0;    // falling edge, one cycle late

	//////////////////////////////////////////////////////////////////////
	// state, bank rotation, frame count
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge cmos_pclk or negedge locked) begin
		if (!locked) begin
			state_q    <= (FRAME_SKIP == 0) ? FILL : SKIP;    // no settling wanted
			skip_cnt_q <= '0;
			bank_q     <= '0;
			count_q    <= '0;
		end else if (frame_end) begin
			case (state_q)
				SKIP: begin
					if (skip_cnt_q == SKIP_W'(FRAME_SKIP - 1)) begin
						state_q <= FILL;    // next frame lands in bank 0
					end else begin
						skip_cnt_q <= skip_cnt_q + 1'b1;
					end
				end
				FILL: begin
					bank_q  <= next_bank(bank_q);
					count_q <= count_q + 1'b1;
					// banks 0 and 1 now hold old and prev
					if (bank_q == bank_idx_t'(1)) begin
						state_q <= RUN;
					end
				end
				RUN: begin
					bank_q  <= next_bank(bank_q);
					count_q <= count_q + 1'b1;
				end
				default: state_q <= SKIP;
			endcase
		end
	end

	assign store_en_o    = (state_q != SKIP);
	assign primed_o      = (state_q == RUN);    // sticky until reset
	assign wr_bank_o     = bank_q;
	assign frame_count_o = count_q;

endmodule

// ==== design/motion_pkg.sv ====
package motion_pkg;

	//////////////////////////////////////////////////////////////////////
	// image constants
	//////////////////////////////////////////////////////////////////////
	localparam int PIX_W     = 8;    // grey sample width
	localparam int NUM_BANKS = 3;    // cur, prev, old

	typedef logic [PIX_W-1:0] pixel_t;
	typedef logic [1:0]       bank_idx_t;    // 0..2 only

	localparam pixel_t PIX_BLACK = 8'h00;    // motion marker
	localparam pixel_t PIX_WHITE = 8'hFF;    // still background

	//////////////////////////////////////////////////////////////////////
	// csr map
	//////////////////////////////////////////////////////////////////////
	localparam int APB_ADDR_W = 4;

	localparam logic [APB_ADDR_W-1:0] CSR_CTRL_ADDR   = 4'h0;    // [0] diff_mode
	localparam logic [APB_ADDR_W-1:0] CSR_THRESH_ADDR = 4'h4;    // [7:0] threshold
	localparam logic [APB_ADDR_W-1:0] CSR_STATUS_ADDR = 4'h8;    // [8] primed, [7:0] count

	localparam pixel_t DEFAULT_THRESH    = 8'd20;
	localparam logic   DEFAULT_DIFF_MODE = 1'b1;

	// sensor side stream, one sample per pclk while href
	typedef struct packed {
		logic   vsync;    // high for the whole frame
		logic   href;     // pixel qualifier
		pixel_t pixel;
	} cam_pix_t;

	// same address across the three stored frames
	typedef struct packed {
		logic   vsync;
		logic   valid;
		pixel_t cur;     // incoming frame
		pixel_t prev;    // one frame back
		pixel_t old;     // two frames back
	} pix_triple_t;

	typedef struct packed {
		logic   vsync;
		logic   valid;
		pixel_t pixel;
	} pix_out_t;

endpackage
